//--- include/cpu86_config.svh
`ifndef CPU86_CONFIG_SVH
`define CPU86_CONFIG_SVH

// **************************************************
// Core dimensions
// **************************************************
`define CPU86_WORD_W       16
`define CPU86_ADDR_W       20
`define CPU86_NUM_REGS     8

// Longest kept instruction is three bytes.
`define CPU86_QUEUE_DEPTH  3

// Returned by unloaded ROM.
`define CPU86_NOP_BYTE     8'h90

`endif

//--- hdl/cpu86_pkg.sv
`default_nettype none

`include "cpu86_config.svh"

package cpu86_pkg;

    typedef logic [`CPU86_WORD_W-1:0] word_t;
    typedef logic [7:0]               byte_t;

    // 8086 order AX CX DX BX SP BP SI DI.
    typedef logic [2:0] reg_idx_t;

    localparam reg_idx_t REG_AX = 3'd0;
    localparam reg_idx_t REG_SP = 3'd4;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_MOV_IMM,
        OP_LOAD_ACC,
        OP_STORE_ACC,
        OP_ADD,
        OP_ADC,
        OP_INC,
        OP_PUSH,
        OP_POP,
        OP_PUSHF
    } op_kind_t;

    // Head byte plus the two that follow it.
    typedef struct packed {
        logic  head_valid;
        byte_t opcode;
        byte_t op1;
        byte_t op2;
    } inst_window_t;

    typedef struct packed {
        logic     valid;
        op_kind_t kind;
        logic     is_word;
        reg_idx_t reg_idx;
        word_t    imm;
        word_t    addr;
    } decoded_t;

    // 8086 bit positions.
    typedef struct packed {
        logic [3:0] rsvd_15_12;
        logic       of;
        logic [2:0] rsvd_10_8;
        logic       sf;
        logic       zf;
        logic       rsvd_5;
        logic       af;
        logic       rsvd_3;
        logic       pf;
        logic       rsvd_1;
        logic       cf;
    } flags_t;

    typedef struct packed {
        logic                     en;
        logic                     word;
        logic [`CPU86_ADDR_W-1:0] addr;
    } ram_rd_req_t;

    typedef struct packed {
        logic                     en;
        logic                     word;
        logic [`CPU86_ADDR_W-1:0] addr;
        word_t                    data;
    } ram_wr_req_t;

endpackage

`default_nettype wire

//--- hdl/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu86_config.svh"

module fetch_queue (
    input  wire                              clk,
    input  wire                              rst,
    input  wire cpu86_pkg::byte_t            rom_data,
    output logic                             rom_en,
    output logic [`CPU86_ADDR_W-1:0]         rom_addr,
    output cpu86_pkg::inst_window_t          window
);

    localparam int DEPTH = `CPU86_QUEUE_DEPTH;

    cpu86_pkg::word_t                   pc;
    cpu86_pkg::byte_t [DEPTH-1:0]       slot;
    logic [DEPTH-1:0]                   slot_valid;
    logic [DEPTH-1:0]                   slot_start;
    logic                               start_in;

    // Instruction length from the opcode alone.
    function automatic logic [1:0] inst_len(cpu86_pkg::byte_t op);
        if (op[7:3] == 5'b10111 || op[7:2] == 6'b101000 || op == 8'h05 || op == 8'h15) begin
            return 2'd3;
        end else if (op[7:3] == 5'b10110 || op == 8'h04 || op == 8'h14) begin
            return 2'd2;
        end
        return 2'd1;
    endfunction

    assign rom_en   = rst;
    assign rom_addr = {{(`CPU86_ADDR_W-`CPU86_WORD_W){1'b0}}, pc};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc <= '0;
        end else begin
            pc <= pc + 1'b1;
        end
    end

    // **************************************************
    // Start marker
    // **************************************************
    always_comb begin
        start_in = !slot_valid[0];                       // First byte after reset.
        for (int i = 0; i < DEPTH; i++) begin
            if (slot_valid[i] && slot_start[i] && inst_len(slot[i]) == 2'(i + 1)) begin
                start_in = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            slot_valid <= '0;
            slot_start <= '0;
        end else begin
            slot_valid <= {slot_valid[DEPTH-2:0], 1'b1};
            slot_start <= {slot_start[DEPTH-2:0], start_in};
        end
    end

    always_ff @(posedge clk) begin
        slot <= {slot[DEPTH-2:0], rom_data};
    end

    assign window.head_valid = slot_valid[DEPTH-1] && slot_start[DEPTH-1];
    assign window.opcode     = slot[DEPTH-1];
    assign window.op1        = slot[DEPTH-2];
    assign window.op2        = slot[DEPTH-3];

endmodule

`default_nettype wire

//--- hdl/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  wire cpu86_pkg::inst_window_t window,
    output cpu86_pkg::decoded_t          dec
);

    always_comb begin
        dec.valid   = window.head_valid;
        dec.kind    = cpu86_pkg::OP_NOP;
        dec.is_word = 1'b1;
        dec.reg_idx = window.opcode[2:0];
        dec.imm     = {window.op2, window.op1};      // Little-endian.
        dec.addr    = {window.op2, window.op1};

        casez (window.opcode)
            8'b1011_0???: begin
                dec.kind    = cpu86_pkg::OP_MOV_IMM;
                dec.is_word = 1'b0;
                dec.imm     = {8'h00, window.op1};
            end
            8'b1011_1???: begin
                dec.kind = cpu86_pkg::OP_MOV_IMM;
            end
            8'b1010_000?: begin
                dec.kind    = cpu86_pkg::OP_LOAD_ACC;
                dec.is_word = window.opcode[0];
                dec.reg_idx = cpu86_pkg::REG_AX;
            end
            8'b1010_001?: begin
                dec.kind    = cpu86_pkg::OP_STORE_ACC;
                dec.is_word = window.opcode[0];
                dec.reg_idx = cpu86_pkg::REG_AX;
            end
            8'b000?_010?: begin
                // 04/05 add, 14/15 add with carry.
                dec.kind    = window.opcode[4] ? cpu86_pkg::OP_ADC : cpu86_pkg::OP_ADD;
                dec.is_word = window.opcode[0];
                dec.reg_idx = cpu86_pkg::REG_AX;
                if (!window.opcode[0]) begin
                    dec.imm = {8'h00, window.op1};
                end
            end
            8'b0100_0???: begin
                dec.kind = cpu86_pkg::OP_INC;
            end
            8'b0101_0???: begin
                dec.kind = cpu86_pkg::OP_PUSH;
            end
            8'b0101_1???: begin
                dec.kind = cpu86_pkg::OP_POP;
            end
            8'h9c: begin
                dec.kind = cpu86_pkg::OP_PUSHF;
            end
            default: begin
                dec.kind = cpu86_pkg::OP_NOP;            // Unknown bytes act as NOP.
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu86_config.svh"

module reg_file (
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire                                        wr_en,
    input  wire                                        wr_word,
    input  wire cpu86_pkg::reg_idx_t                   wr_idx,
    input  wire cpu86_pkg::word_t                      wr_data,
    input  wire                                        sp_en,
    input  wire cpu86_pkg::word_t                      sp_next,
    output cpu86_pkg::word_t [`CPU86_NUM_REGS-1:0]     regs
);

    cpu86_pkg::reg_idx_t byte_reg;

    // Byte index 4..7 selects AH..BH.
    assign byte_reg = {1'b0, wr_idx[1:0]};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regs <= '0;
        end else begin
            if (wr_en) begin
                if (wr_word) begin
                    regs[wr_idx] <= wr_data;
                end else if (wr_idx[2]) begin
                    regs[byte_reg][15:8] <= wr_data[7:0];
                end else begin
                    regs[byte_reg][7:0] <= wr_data[7:0];
                end
            end
            // Later assignment wins, so SP update beats POP SP.
            if (sp_en) begin
                regs[cpu86_pkg::REG_SP] <= sp_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/alu_flags.sv
`timescale 1ns/1ps
`default_nettype none

module alu_flags (
    input  wire cpu86_pkg::word_t  a,
    input  wire cpu86_pkg::word_t  b,
    input  wire                    carry_in,
    input  wire                    is_word,
    input  wire                    is_inc,
    input  wire cpu86_pkg::flags_t flags_in,
    output cpu86_pkg::word_t       result,
    output cpu86_pkg::flags_t      flags_out
);

    logic [16:0] sum;
    logic        carry_b;
    logic        msb_a;
    logic        msb_b;
    logic        msb_r;

    assign sum     = {1'b0, a} + {1'b0, b} + {16'h0000, carry_in};
    assign carry_b = sum[8] ^ a[8] ^ b[8];           // Carry out of bit 7.
    assign result  = is_word ? sum[15:0] : {8'h00, sum[7:0]};

    assign msb_a = is_word ? a[15] : a[7];
    assign msb_b = is_word ? b[15] : b[7];
    assign msb_r = is_word ? result[15] : result[7];

    always_comb begin
        flags_out    = '0;
        flags_out.cf = is_inc ? flags_in.cf : (is_word ? sum[16] : carry_b);
        flags_out.pf = ~^result[7:0];                // Even parity, low byte only.
        flags_out.af = a[4] ^ b[4] ^ result[4];
        flags_out.zf = (result == '0);
        flags_out.sf = msb_r;
        flags_out.of = (msb_a == msb_b) && (msb_r != msb_a);
    end

endmodule

`default_nettype wire

//--- hdl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu86_config.svh"

module exec_unit (
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire cpu86_pkg::decoded_t                   dec,
    input  wire cpu86_pkg::word_t [`CPU86_NUM_REGS-1:0] regs,
    input  wire cpu86_pkg::word_t                      ram_rd_data,
    output cpu86_pkg::ram_rd_req_t                     ram_rd,
    output cpu86_pkg::ram_wr_req_t                     ram_wr,
    output logic                                       wr_en,
    output logic                                       wr_word,
    output cpu86_pkg::reg_idx_t                        wr_idx,
    output cpu86_pkg::word_t                           wr_data,
    output logic                                       sp_en,
    output cpu86_pkg::word_t                           sp_next,
    output cpu86_pkg::word_t                           alu_a,
    output cpu86_pkg::word_t                           alu_b,
    output logic                                       alu_carry,
    output logic                                       alu_word,
    output logic                                       alu_inc,
    output cpu86_pkg::flags_t                          flags,
    input  wire cpu86_pkg::word_t                      alu_result,
    input  wire cpu86_pkg::flags_t                     new_flags
);

    logic             alu_op;
    logic             is_push;
    logic             is_pop;
    cpu86_pkg::word_t sp;
    cpu86_pkg::word_t sp_dec;

    assign sp      = regs[cpu86_pkg::REG_SP];
    assign sp_dec  = sp - 16'd2;
    assign is_pop  = dec.kind == cpu86_pkg::OP_POP;
    assign is_push = dec.kind inside {cpu86_pkg::OP_PUSH, cpu86_pkg::OP_PUSHF};
    assign alu_op  = dec.valid &&
                     dec.kind inside {cpu86_pkg::OP_ADD, cpu86_pkg::OP_ADC, cpu86_pkg::OP_INC};

    // **************************************************
    // RAM requests
    // **************************************************
    always_comb begin
        ram_rd      = '0;
        ram_rd.en   = dec.valid && (dec.kind == cpu86_pkg::OP_LOAD_ACC || is_pop);
        ram_rd.word = dec.is_word;
        ram_rd.addr[`CPU86_WORD_W-1:0] = is_pop ? sp : dec.addr;
    end

    always_comb begin
        ram_wr      = '0;
        ram_wr.en   = dec.valid && (dec.kind == cpu86_pkg::OP_STORE_ACC || is_push);
        ram_wr.word = dec.is_word;
        ram_wr.addr[`CPU86_WORD_W-1:0] = is_push ? sp_dec : dec.addr;
        // Store names AX in reg_idx, so one select serves store and push.
        ram_wr.data = (dec.kind == cpu86_pkg::OP_PUSHF) ? cpu86_pkg::word_t'(flags)
                                                        : regs[dec.reg_idx];
    end

    // **************************************************
    // Write-back
    // **************************************************
    assign wr_en   = dec.valid && !(dec.kind inside {cpu86_pkg::OP_NOP,
                                                     cpu86_pkg::OP_STORE_ACC,
                                                     cpu86_pkg::OP_PUSH,
                                                     cpu86_pkg::OP_PUSHF});
    assign wr_word = dec.is_word;
    assign wr_idx  = dec.reg_idx;

    always_comb begin
        case (dec.kind)
            cpu86_pkg::OP_MOV_IMM:  wr_data = dec.imm;
            cpu86_pkg::OP_LOAD_ACC,
            cpu86_pkg::OP_POP:      wr_data = ram_rd_data;
            default:                wr_data = alu_result;
        endcase
    end

    assign sp_en   = dec.valid && (is_push || is_pop);
    assign sp_next = is_pop ? sp + 16'd2 : sp_dec;

    // Accumulator forms decode reg_idx as AX.
    assign alu_a     = regs[dec.reg_idx];
    assign alu_b     = (dec.kind == cpu86_pkg::OP_INC) ? 16'd1 : dec.imm;
    assign alu_carry = (dec.kind == cpu86_pkg::OP_ADC) && flags.cf;
    assign alu_word  = dec.is_word;
    assign alu_inc   = dec.kind == cpu86_pkg::OP_INC;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flags <= '0;
        end else if (alu_op) begin
            flags <= new_flags;
        end
    end

endmodule

`default_nettype wire

//--- hdl/cpu86_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu86_config.svh"

module cpu86_core (
    input  wire                          clk,
    input  wire                          rst,
    output logic                         rom_en,
    output logic [`CPU86_ADDR_W-1:0]     rom_addr,
    input  wire cpu86_pkg::byte_t        rom_data,
    output cpu86_pkg::ram_rd_req_t       ram_rd,
    input  wire cpu86_pkg::word_t        ram_rd_data,
    output cpu86_pkg::ram_wr_req_t       ram_wr
);

    cpu86_pkg::inst_window_t                 window;
    cpu86_pkg::decoded_t                     dec;
    cpu86_pkg::word_t [`CPU86_NUM_REGS-1:0]  regs;

    logic                                    wr_en;
    logic                                    wr_word;
    cpu86_pkg::reg_idx_t                     wr_idx;
    cpu86_pkg::word_t                        wr_data;
    logic                                    sp_en;
    cpu86_pkg::word_t                        sp_next;

    cpu86_pkg::word_t                        alu_a;
    cpu86_pkg::word_t                        alu_b;
    logic                                    alu_carry;
    logic                                    alu_word;
    logic                                    alu_inc;
    cpu86_pkg::word_t                        alu_result;
    cpu86_pkg::flags_t                       flags;
    cpu86_pkg::flags_t                       new_flags;

    fetch_queue u_fetch_queue (
        .clk      (clk),
        .rst      (rst),
        .rom_data (rom_data),
        .rom_en   (rom_en),
        .rom_addr (rom_addr),
        .window   (window)
    );

    inst_decode u_inst_decode (
        .window (window),
        .dec    (dec)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_word (wr_word),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .sp_en   (sp_en),
        .sp_next (sp_next),
        .regs    (regs)
    );

    alu_flags u_alu_flags (
        .a         (alu_a),
        .b         (alu_b),
        .carry_in  (alu_carry),
        .is_word   (alu_word),
        .is_inc    (alu_inc),
        .flags_in  (flags),
        .result    (alu_result),
        .flags_out (new_flags)
    );

    exec_unit u_exec_unit (
        .clk         (clk),
        .rst         (rst),
        .dec         (dec),
        .regs        (regs),
        .ram_rd_data (ram_rd_data),
        .ram_rd      (ram_rd),
        .ram_wr      (ram_wr),
        .wr_en       (wr_en),
        .wr_word     (wr_word),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data),
        .sp_en       (sp_en),
        .sp_next     (sp_next),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_carry   (alu_carry),
        .alu_word    (alu_word),
        .alu_inc     (alu_inc),
        .flags       (flags),
        .alu_result  (alu_result),
        .new_flags   (new_flags)
    );

endmodule

`default_nettype wire

//--- dv/cpu86_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu86_config.svh"

module cpu86_mem_model (
    input  wire                          clk,
    input  wire                          rom_en,
    input  wire [`CPU86_ADDR_W-1:0]      rom_addr,
    output cpu86_pkg::byte_t             rom_data,
    input  wire cpu86_pkg::ram_rd_req_t  ram_rd,
    output cpu86_pkg::word_t             ram_rd_data,
    input  wire cpu86_pkg::ram_wr_req_t  ram_wr
);

    localparam int MEM_BYTES = 1 << `CPU86_WORD_W;

    cpu86_pkg::byte_t rom [MEM_BYTES];
    cpu86_pkg::byte_t ram [MEM_BYTES];
    int unsigned      wr_count;

    cpu86_pkg::word_t rd_lo;
    cpu86_pkg::word_t rd_hi;
    cpu86_pkg::word_t wr_lo;
    cpu86_pkg::word_t wr_hi;

    assign rd_lo = ram_rd.addr[`CPU86_WORD_W-1:0];
    assign rd_hi = rd_lo + 16'd1;
    assign wr_lo = ram_wr.addr[`CPU86_WORD_W-1:0];
    assign wr_hi = wr_lo + 16'd1;

    assign rom_data    = rom_en ? rom[rom_addr[`CPU86_WORD_W-1:0]] : `CPU86_NOP_BYTE;
    assign ram_rd_data = ram_rd.word ? {ram[rd_hi], ram[rd_lo]} : {8'h00, ram[rd_lo]};

    initial begin
        wr_count = 0;
    end

    // Little-endian write, counted once per request.
    always @(posedge clk) begin
        if (ram_wr.en) begin
            ram[wr_lo] = ram_wr.data[7:0];
            if (ram_wr.word) begin
                ram[wr_hi] = ram_wr.data[15:8];
            end
            wr_count = wr_count + 1;
        end
    end

endmodule

`default_nettype wire

//--- dv/cpu86_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu86_config.svh"

module cpu86_asserts (
    input  wire                          clk,
    input  wire                          rst,
    input  wire cpu86_pkg::ram_rd_req_t  ram_rd,
    input  wire cpu86_pkg::ram_wr_req_t  ram_wr
);

    localparam int TOP = `CPU86_ADDR_W - 1;

    // Queue is still filling when reset lifts.
    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst) |-> !ram_rd.en && !ram_wr.en)
        else $error("RAM enable high in the first cycle after reset");

    one_port_per_cycle: assert property (@(posedge clk) disable iff (!rst)
        !(ram_rd.en && ram_wr.en))
        else $error("RAM read and write enabled in the same cycle");

    addr_top_zero: assert property (@(posedge clk) disable iff (!rst)
        ram_rd.addr[TOP -: 4] == 4'h0 && ram_wr.addr[TOP -: 4] == 4'h0)
        else $error("RAM address has nonzero top bits");

endmodule

`default_nettype wire

//--- dv/cpu86_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu86_config.svh"

module cpu86_tb;

    localparam logic [15:0] SEED        = 16'd48844;
    localparam logic [15:0] LFSR_TAPS   = 16'hB400;
    localparam int          WAIT_CYCLES = 200;
    localparam int          RST_CYCLES  = 8;
    localparam int          MEM_BYTES   = 1 << `CPU86_WORD_W;

    localparam cpu86_pkg::byte_t OPC_MOV_R8   = 8'hB0;
    localparam cpu86_pkg::byte_t OPC_MOV_R16  = 8'hB8;
    localparam cpu86_pkg::byte_t OPC_LOAD_AL  = 8'hA0;
    localparam cpu86_pkg::byte_t OPC_LOAD_AX  = 8'hA1;
    localparam cpu86_pkg::byte_t OPC_STORE_AL = 8'hA2;
    localparam cpu86_pkg::byte_t OPC_STORE_AX = 8'hA3;
    localparam cpu86_pkg::byte_t OPC_ADD_AL   = 8'h04;
    localparam cpu86_pkg::byte_t OPC_ADD_AX   = 8'h05;
    localparam cpu86_pkg::byte_t OPC_ADC_AX   = 8'h15;
    localparam cpu86_pkg::byte_t OPC_INC      = 8'h40;
    localparam cpu86_pkg::byte_t OPC_PUSH     = 8'h50;
    localparam cpu86_pkg::byte_t OPC_POP      = 8'h58;
    localparam cpu86_pkg::byte_t OPC_PUSHF    = 8'h9C;

    localparam logic [2:0] R_CX = 3'd1;
    localparam logic [2:0] R_BX = 3'd3;

    localparam int CF_BIT = 0;
    localparam int PF_BIT = 2;
    localparam int AF_BIT = 4;
    localparam int ZF_BIT = 6;
    localparam int SF_BIT = 7;
    localparam int OF_BIT = 11;

    logic                     clk;
    logic                     rst;
    logic                     rom_en;
    logic [`CPU86_ADDR_W-1:0] rom_addr;
    cpu86_pkg::byte_t         rom_data;
    cpu86_pkg::ram_rd_req_t   ram_rd;
    cpu86_pkg::word_t         ram_rd_data;
    cpu86_pkg::ram_wr_req_t   ram_wr;

    logic [15:0]              lfsr;
    int                       errors;
    int                       timeouts;
    int                       checks;
    int unsigned              wr_base;
    cpu86_pkg::byte_t         prog [$];

    cpu86_core u_cpu86_core (
        .clk         (clk),
        .rst         (rst),
        .rom_en      (rom_en),
        .rom_addr    (rom_addr),
        .rom_data    (rom_data),
        .ram_rd      (ram_rd),
        .ram_rd_data (ram_rd_data),
        .ram_wr      (ram_wr)
    );

    cpu86_mem_model u_mem_model (
        .clk         (clk),
        .rom_en      (rom_en),
        .rom_addr    (rom_addr),
        .rom_data    (rom_data),
        .ram_rd      (ram_rd),
        .ram_rd_data (ram_rd_data),
        .ram_wr      (ram_wr)
    );

    bind cpu86_core cpu86_asserts u_cpu86_asserts (
        .clk    (clk),
        .rst    (rst),
        .ram_rd (ram_rd),
        .ram_wr (ram_wr)
    );

    always #50 clk = ~clk;

    // **************************************************
    // Random source and reference model
    // **************************************************
    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ LFSR_TAPS;
        end
        return out;
    endfunction

    function automatic cpu86_pkg::word_t rand_bits(input int n);
        cpu86_pkg::word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic cpu86_pkg::byte_t ram_pattern(input cpu86_pkg::word_t addr);
        return addr[7:0] ^ {addr[11:8], addr[15:12]} ^ 8'hA5;
    endfunction

    function automatic cpu86_pkg::word_t model_sum(input cpu86_pkg::word_t a,
                                                   input cpu86_pkg::word_t b,
                                                   input logic cin,
                                                   input logic is_word);
        return (a + b + cin) & (is_word ? 16'hFFFF : 16'h00FF);
    endfunction

    function automatic cpu86_pkg::word_t model_flags(input cpu86_pkg::word_t a,
                                                     input cpu86_pkg::word_t b,
                                                     input logic cin,
                                                     input logic is_word);
        int unsigned      width;
        int unsigned      mask;
        int unsigned      opa;
        int unsigned      opb;
        int unsigned      full;
        cpu86_pkg::word_t res;
        cpu86_pkg::word_t f;
        width     = is_word ? 16 : 8;
        mask      = (1 << width) - 1;
        opa       = a & mask;
        opb       = b & mask;
        full      = opa + opb + cin;
        res       = 16'(full & mask);
        f         = '0;
        f[CF_BIT] = full > mask;
        f[PF_BIT] = ~^res[7:0];
        f[AF_BIT] = ((opa & 15) + (opb & 15) + cin) > 15;  // Carry out of bit 3.
        f[ZF_BIT] = res == 0;
        f[SF_BIT] = res[width-1];
        f[OF_BIT] = (opa[width-1] == opb[width-1]) && (res[width-1] != opa[width-1]);
        return f;
    endfunction

    // **************************************************
    // Program assembly and run control
    // **************************************************
    task automatic emit(input cpu86_pkg::byte_t b);
        prog.push_back(b);
    endtask

    task automatic emit_op_byte(input cpu86_pkg::byte_t op, input cpu86_pkg::byte_t b);
        prog.push_back(op);
        prog.push_back(b);
    endtask

    task automatic emit_op_word(input cpu86_pkg::byte_t op, input cpu86_pkg::word_t w);
        prog.push_back(op);
        prog.push_back(w[7:0]);                            // Little-endian.
        prog.push_back(w[15:8]);
    endtask

    task automatic start_program();
        @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            if (i < prog.size()) begin
                u_mem_model.rom[i] = prog[i];
            end else begin
                u_mem_model.rom[i] = `CPU86_NOP_BYTE;
            end
            u_mem_model.ram[i] = ram_pattern(i[15:0]);
        end
        prog.delete();
        repeat (RST_CYCLES) @(posedge clk);
        rst     <= 1'b1;
        wr_base = u_mem_model.wr_count;
    endtask

    // Counter is 0 in the first cycle after reset and steps once per cycle.
    task automatic check_fetch(input int cycle);
        logic [`CPU86_ADDR_W-1:0] exp_addr;
        exp_addr = `CPU86_ADDR_W'(cycle);
        checks++;
        assert (rom_en === 1'b1) else begin
            errors++;
            $display("Fail t=%0t rom_en expected 1 actual %b", $time, rom_en);
        end
        assert (rom_addr === exp_addr) else begin
            errors++;
            $display("Fail t=%0t rom_addr expected %05h actual %05h",
                     $time, exp_addr, rom_addr);
        end
    endtask

    task automatic wait_writes(input string test_name, input int count);
        int cycles;
        cycles = 0;
        while ((u_mem_model.wr_count - wr_base) < count && cycles < WAIT_CYCLES) begin
            @(negedge clk);
            check_fetch(cycles);
            cycles++;
        end
        if ((u_mem_model.wr_count - wr_base) < count) begin
            timeouts++;
            $display("Timeout in %s: expected %0d stores never came, saw %0d in %0d cycles",
                     test_name, count, u_mem_model.wr_count - wr_base, cycles);
        end
    endtask

    task automatic check_byte(input string label, input cpu86_pkg::word_t addr,
                              input cpu86_pkg::byte_t exp);
        cpu86_pkg::byte_t act;
        act = u_mem_model.ram[addr];
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Fail t=%0t %s ram[%04h] expected %02h actual %02h",
                     $time, label, addr, exp, act);
        end
    endtask

    task automatic check_word(input string label, input cpu86_pkg::word_t addr,
                              input cpu86_pkg::word_t exp);
        check_byte({label, " lo"}, addr, exp[7:0]);
        check_byte({label, " hi"}, addr + 16'd1, exp[15:8]);
    endtask

    // **************************************************
    // Directed tests
    // **************************************************
    task automatic test_mov_store();
        cpu86_pkg::word_t imm;
        cpu86_pkg::byte_t val;
        imm = rand_bits(16);
        val = 8'(rand_bits(8));
        emit_op_word(OPC_MOV_R16 | cpu86_pkg::REG_AX, imm);
        emit_op_word(OPC_STORE_AX, 16'h0200);
        emit_op_byte(OPC_MOV_R8 | cpu86_pkg::REG_AX, val);
        emit_op_word(OPC_STORE_AL, 16'h0210);
        start_program();
        wait_writes("mov_store", 2);
        check_word("mov ax store", 16'h0200, imm);
        check_byte("mov al store", 16'h0210, val);
        check_byte("above al store", 16'h0211, ram_pattern(16'h0211));
        check_byte("below al store", 16'h020F, ram_pattern(16'h020F));
    endtask

    task automatic run_word_chain(input string label, input cpu86_pkg::word_t init,
                                  input cpu86_pkg::word_t imm0, input cpu86_pkg::word_t imm1,
                                  input cpu86_pkg::word_t imm2, input int n_adc);
        cpu86_pkg::word_t acc;
        cpu86_pkg::word_t flg;
        cpu86_pkg::word_t nxt;
        cpu86_pkg::word_t imm;
        emit_op_word(OPC_MOV_R16 | cpu86_pkg::REG_SP, 16'h0300);
        emit_op_word(OPC_MOV_R16 | cpu86_pkg::REG_AX, init);
        emit_op_word(OPC_ADD_AX, imm0);
        flg = model_flags(init, imm0, 1'b0, 1'b1);
        acc = model_sum(init, imm0, 1'b0, 1'b1);
        for (int i = 1; i <= n_adc; i++) begin
            imm = (i == 1) ? imm1 : imm2;
            emit_op_word(OPC_ADC_AX, imm);
            nxt = model_flags(acc, imm, flg[CF_BIT], 1'b1);
            acc = model_sum(acc, imm, flg[CF_BIT], 1'b1);
            flg = nxt;
        end
        emit(OPC_PUSHF);
        emit_op_word(OPC_STORE_AX, 16'h0400);
        start_program();
        wait_writes(label, 2);
        check_word({label, " flags"}, 16'h02FE, flg);
        check_word({label, " ax"}, 16'h0400, acc);
    endtask

    task automatic test_add_chain();
        cpu86_pkg::word_t v [4];
        for (int run = 0; run < 2; run++) begin
            for (int i = 0; i < 4; i++) begin
                v[i] = rand_bits(16);
            end
            run_word_chain("add adc chain", v[0], v[1], v[2], v[3], 2);
        end
        v[0] = rand_bits(16) | 16'h0001;                     // Nonzero, so the sum wraps.
        run_word_chain("carry to zero", v[0], 16'h0000 - v[0], 16'h0000, 16'h0000, 0);
    endtask

    task automatic test_byte_add();
        cpu86_pkg::byte_t ah;
        cpu86_pkg::byte_t al;
        cpu86_pkg::byte_t b;
        cpu86_pkg::word_t flg;
        cpu86_pkg::word_t sum;
        ah  = 8'(rand_bits(8));
        al  = 8'((rand_bits(8) & 8'h37) | 8'h88);            // Forces CF, AF and OF.
        b   = 8'((rand_bits(8) & 8'h37) | 8'h88);
        emit_op_word(OPC_MOV_R16 | cpu86_pkg::REG_SP, 16'h0300);
        emit_op_word(OPC_MOV_R16 | cpu86_pkg::REG_AX, {ah, al});
        emit_op_byte(OPC_ADD_AL, b);
        emit(OPC_PUSHF);
        emit_op_word(OPC_STORE_AX, 16'h0500);
        flg = model_flags({ah, al}, {8'h00, b}, 1'b0, 1'b0);
        sum = model_sum({ah, al}, {8'h00, b}, 1'b0, 1'b0);
        start_program();
        wait_writes("byte_add", 2);
        check_word("byte add flags", 16'h02FE, flg);
        check_byte("byte add al", 16'h0500, sum[7:0]);
        check_byte("byte add ah kept", 16'h0501, ah);
    endtask

    task automatic test_stack();
        cpu86_pkg::word_t v;
        cpu86_pkg::word_t pre;
        cpu86_pkg::word_t flg;
        v   = rand_bits(16);
        emit_op_word(OPC_MOV_R16 | cpu86_pkg::REG_SP, 16'h0600);
        emit_op_word(OPC_MOV_R16 | R_BX, v);
        emit(OPC_PUSH | R_BX);
        emit(OPC_POP | R_CX);
        emit(OPC_PUSH | R_CX);
        emit_op_word(OPC_MOV_R16 | cpu86_pkg::REG_AX, 16'hFFFF);
        emit_op_word(OPC_ADD_AX, 16'h0001);                 // Sets CF before the INC.
        emit(OPC_INC | R_CX);
        emit(OPC_PUSH | R_CX);
        emit(OPC_PUSHF);
        pre         = model_flags(16'hFFFF, 16'h0001, 1'b0, 1'b1);
        flg         = model_flags(v, 16'h0001, 1'b0, 1'b1);
        flg[CF_BIT] = pre[CF_BIT];
        start_program();
        wait_writes("stack", 4);
        check_word("bx through pop cx", 16'h05FE, v);
        check_word("incremented cx", 16'h05FC, v + 16'd1);
        check_word("flags after inc", 16'h05FA, flg);
    endtask

    task automatic test_load_copy();
        cpu86_pkg::word_t src;
        emit_op_word(OPC_LOAD_AX, 16'h0700);
        emit(8'hF4);                                         // One-byte unknown opcodes.
        emit(8'hCC);
        emit_op_word(OPC_STORE_AX, 16'h0800);
        emit(8'h27);
        emit_op_word(OPC_LOAD_AL, 16'h0720);
        emit(8'hF4);
        emit_op_word(OPC_STORE_AL, 16'h0900);
        emit_op_word(OPC_STORE_AX, 16'h0A00);
        src = {ram_pattern(16'h0701), ram_pattern(16'h0700)};
        start_program();
        wait_writes("load_copy", 3);
        check_word("word copy", 16'h0800, src);
        check_byte("byte copy", 16'h0900, ram_pattern(16'h0720));
        check_byte("above byte copy", 16'h0901, ram_pattern(16'h0901));
        check_word("ax after byte load", 16'h0A00, {src[15:8], ram_pattern(16'h0720)});
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b0;
        lfsr     = SEED;
        errors   = 0;
        timeouts = 0;
        checks   = 0;
        wr_base  = 0;
        test_mov_store();
        test_add_chain();
        test_byte_add();
        test_stack();
        test_load_copy();
        $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
hdl/cpu86_pkg.sv
hdl/fetch_queue.sv
hdl/inst_decode.sv
hdl/reg_file.sv
hdl/alu_flags.sv
hdl/exec_unit.sv
hdl/cpu86_core.sv
dv/cpu86_mem_model.sv
dv/cpu86_asserts.sv
dv/cpu86_tb.sv

//--- Bender.yml
package:
  name: cpu86

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/cpu86_pkg.sv
      - hdl/fetch_queue.sv
      - hdl/inst_decode.sv
      - hdl/reg_file.sv
      - hdl/alu_flags.sv
      - hdl/exec_unit.sv
      - hdl/cpu86_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/cpu86_mem_model.sv
      - dv/cpu86_asserts.sv
      - dv/cpu86_tb.sv
